// ==== tests/cache_trace.txt ====
# op addr strobe wdata expected_rdata, all hex
# stores ignore the last column, loads ignore strobe and wdata
R 00001000 0 00000000 5a5a1000
R 00001004 0 00000000 5a5a1004
R 00001008 0 00000000 5a5a1008
R 0000100c 0 00000000 5a5a100c
R 00001000 0 00000000 5a5a1000
W 00001004 3 11223344 00000000
R 00001004 0 00000000 5a5a3344
W 00001008 4 99887766 00000000
R 00001008 0 00000000 5a881008
R 00001000 0 00000000 5a5a1000
W 00002010 c aabbccdd 00000000
R 00002010 0 00000000 aabb2010
R 00002014 0 00000000 5a5a2014
W 00003020 1 000000ef 00000000
R 00003020 0 00000000 5a5a30ef
R 00000050 0 00000000 5a5a0050
W 00000054 f 01010101 00000000
R 00000250 0 00000000 5a5a0250
W 0000025c f 02020202 00000000
R 00000450 0 00000000 5a5a0450
W 00000458 f 03030303 00000000
R 00000650 0 00000000 5a5a0650
W 00000654 3 0404abcd 00000000
R 00000054 0 00000000 01010101
R 00000050 0 00000000 5a5a0050
R 0000025c 0 00000000 02020202
R 00000458 0 00000000 03030303
R 00000654 0 00000000 5a5aabcd
R 00000850 0 00000000 5a5a0850
R 00000054 0 00000000 01010101
R 0000025c 0 00000000 02020202
R 00001004 0 00000000 5a5a3344
R 0000100c 0 00000000 5a5a100c
R 00002010 0 00000000 aabb2010

// ==== files.f ====
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/victim_lfsr.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/way_select.sv
hdl/cache_top.sv
tests/cache_tb.sv

// ==== tests/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	localparam int TIMEOUT = 200;

	logic   clk;
	logic   rst_n;
	logic   req;
	logic   we;
	addr_t  addr;
	strb_t  wstrb;
	word_t  wdata;
	word_t  rdata;
	logic   addr_ok;
	logic   data_ok;
	logic   rd_req;
	addr_t  rd_addr;
	logic   rd_rdy;
	logic   ret_valid;
	logic   ret_last;
	word_t  ret_data;
	logic   wr_req;
	addr_t  wr_addr;
	wr_op_t wr_op;
	strb_t  wr_strb;
	line_t  wr_data;
	logic   wr_rdy;

	integer seed = 32'h9664;
	int     mismatches = 0;
	int     timeouts = 0;
	int     faults = 0;

	// sparse memory keyed by word address
	word_t  mem [addr_t];
	int     line_reads = 0;
	int     line_writes = 0;
	int     word_writes = 0;
	addr_t  last_rd_addr;
	addr_t  last_wr_addr;
	strb_t  last_wr_strb;

	// accepted requests in order
	logic   q_we [$];
	addr_t  q_addr [$];
	strb_t  q_strb [$];
	word_t  q_exp [$];
	int     q_edge [$];
	int     edge_n = 0;
	int     seen_reads = 0;
	int     seen_lwrites = 0;
	int     seen_wwrites = 0;

	cache_top #(.WAYS(2)) cache_top_i (
		.clk(clk), .rst_n(rst_n), .req(req), .we(we), .addr(addr), .wstrb(wstrb),
		.wdata(wdata), .rdata(rdata), .addr_ok(addr_ok), .data_ok(data_ok),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
		.ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
		.wr_op(wr_op), .wr_strb(wr_strb), .wr_data(wr_data), .wr_rdy(wr_rdy)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// untouched words follow the address rule
	function automatic word_t mem_word(input addr_t a);
		addr_t wa;
		wa = {a[31:2], 2'b00};
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return wa ^ 32'h5a5a_0000;
	endfunction

	task automatic serve_read();
		addr_t base;
		int    idle;
		int    gap;
		base = rd_addr;
		check_value("rd_addr alignment", base[3:0], 0);
		idle = $unsigned($random(seed)) % 4;
		// request must not move while rd_rdy is low
		for (int i = 0; i < idle; i++) begin
			@(posedge clk);
			check_value("rd_req held", rd_req, 1);
			check_value("rd_addr held", rd_addr, base);
		end
		rd_rdy <= 1'b1;
		@(posedge clk);
		check_value("rd_req at rd_rdy", rd_req, 1);
		check_value("rd_addr at rd_rdy", rd_addr, base);
		rd_rdy <= 1'b0;
		line_reads++;
		last_rd_addr = base;
		// beats in word order with random gaps
		for (int beat = 0; beat < WORDS_PER_LINE; beat++) begin
			gap = $unsigned($random(seed)) % 3;
			ret_valid <= 1'b0;
			ret_last <= 1'b0;
			repeat (gap) @(posedge clk);
			ret_valid <= 1'b1;
			ret_data <= mem_word(base + 4 * beat);
			ret_last <= (beat == WORDS_PER_LINE - 1);
			@(posedge clk);
		end
		ret_valid <= 1'b0;
		ret_last <= 1'b0;
	endtask

	task automatic check_write_held(input addr_t a, input wr_op_t op, input strb_t s,
		input line_t d);
		check_value("wr_req held", wr_req, 1);
		check_value("wr_addr held", wr_addr, a);
		check_value("wr_op held", wr_op, op);
		check_value("wr_strb held", wr_strb, s);
		check_value("wr_data held", wr_data == d, 1);
	endtask

	task automatic serve_write();
		addr_t  a;
		wr_op_t op;
		strb_t  s;
		line_t  d;
		word_t  w;
		int     idle;
		a = wr_addr;
		op = wr_op;
		s = wr_strb;
		d = wr_data;
		idle = $unsigned($random(seed)) % 4;
		for (int i = 0; i < idle; i++) begin
			@(posedge clk);
			check_write_held(a, op, s, d);
		end
		wr_rdy <= 1'b1;
		@(posedge clk);
		check_write_held(a, op, s, d);
		wr_rdy <= 1'b0;
		if (op == op_line) begin
			check_value("line write alignment", a[3:0], 0);
			check_value("line write strobe", s, 4'hf);
			for (int i = 0; i < WORDS_PER_LINE; i++) begin
				mem[a + 4 * i] = d[32*i +: 32];
			end
			line_writes++;
		end else begin
			// merge under strobe
			w = mem_word(a);
			for (int b = 0; b < 4; b++) begin
				if (s[b]) begin
					w[8*b +: 8] = d[8*b +: 8];
				end
			end
			mem[{a[31:2], 2'b00}] = w;
			word_writes++;
			last_wr_addr = a;
			last_wr_strb = s;
		end
	endtask

	// memory side responder
	initial begin
		rd_rdy = 1'b0;
		wr_rdy = 1'b0;
		ret_valid = 1'b0;
		ret_last = 1'b0;
		ret_data = '0;
		forever begin
			@(posedge clk);
			if (rst_n && rd_req) begin
				serve_read();
			end else if (rst_n && wr_req) begin
				serve_write();
			end
		end
	end

	task automatic collect_response();
		logic  is_we;
		addr_t a;
		strb_t s;
		word_t e;
		int    acc;
		int    dr;
		int    dlw;
		int    dww;
		if (q_we.size() == 0) begin
			faults++;
			$display("data_ok at %0t with no request outstanding", $time);
		end else begin
			is_we = q_we.pop_front();
			a = q_addr.pop_front();
			s = q_strb.pop_front();
			e = q_exp.pop_front();
			acc = q_edge.pop_front();
			// memory traffic since the previous response
			dr = line_reads - seen_reads;
			dlw = line_writes - seen_lwrites;
			dww = word_writes - seen_wwrites;
			seen_reads = line_reads;
			seen_lwrites = line_writes;
			seen_wwrites = word_writes;
			if (is_we) begin
				// stores never allocate
				check_value("line reads on store", dr, 0);
				check_value("line writes on store", dlw, 0);
				if (dww == 0) begin
					check_value("store hit latency", edge_n - acc, 1);
					// a hit leaves the next request free to go in
					check_value("addr_ok after store hit", addr_ok, 1);
				end else begin
					check_value("word writes per store", dww, 1);
					check_value("word write address", last_wr_addr, {a[31:2], 2'b00});
					check_value("word write strobe", last_wr_strb, s);
				end
			end else begin
				check_value($sformatf("rdata for %h", a), rdata, e);
				check_value("word writes on load", dww, 0);
				if (dr == 0) begin
					check_value("load hit latency", edge_n - acc, 1);
					check_value("writeback without refill", dlw, 0);
					check_value("addr_ok after load hit", addr_ok, 1);
				end else begin
					check_value("line reads per load", dr, 1);
					check_value("line read address", last_rd_addr,
						{a[31:OFFSET_W], {OFFSET_W{1'b0}}});
				end
			end
		end
	endtask

	// one clock edge and any response due on it
	task automatic tick();
		@(posedge clk);
		edge_n++;
		if (data_ok) begin
			collect_response();
		end
	endtask

	task automatic issue_request(input logic is_we, input addr_t a, input strb_t s,
		input word_t d, input word_t e, output logic ok);
		int n;
		req <= 1'b1;
		we <= is_we;
		addr <= a;
		wstrb <= s;
		wdata <= d;
		n = 0;
		ok = 1'b0;
		while (!ok && n < TIMEOUT) begin
			tick();
			ok = addr_ok;
			n++;
		end
		if (ok) begin
			q_we.push_back(is_we);
			q_addr.push_back(a);
			q_strb.push_back(s);
			q_exp.push_back(e);
			q_edge.push_back(edge_n);
		end else begin
			timeouts++;
			$display("timed out waiting for addr_ok on request to %h", a);
		end
	endtask

	task automatic wait_all_done(output logic ok);
		int n;
		req <= 1'b0;
		n = 0;
		while (q_we.size() != 0 && n < TIMEOUT) begin
			tick();
			n++;
		end
		ok = (q_we.size() == 0);
		if (!ok) begin
			timeouts++;
			$display("timed out waiting for data_ok of %0d requests", q_we.size());
		end
	endtask

	initial begin : run_trace
		int         fd;
		int         n;
		string      text;
		logic [7:0] op;
		addr_t      a;
		strb_t      s;
		word_t      d;
		word_t      e;
		logic       ok;
		clk = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wstrb = '0;
		wdata = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// idle state straight out of reset
		check_value("addr_ok after reset", addr_ok, 1);
		check_value("data_ok after reset", data_ok, 0);
		check_value("rd_req after reset", rd_req, 0);
		check_value("wr_req after reset", wr_req, 0);
		fd = $fopen("tests/cache_trace.txt", "r");
		ok = 1'b1;
		if (fd == 0) begin
			faults++;
			ok = 1'b0;
			$display("cannot open trace file tests/cache_trace.txt");
		end
		while (ok && !$feof(fd)) begin
			n = $fgets(text, fd);
			// skip comments and blank lines
			if (n > 0 && text[0] != "#") begin
				n = $sscanf(text, "%c %h %h %h %h", op, a, s, d, e);
				if (n == 5) begin
					issue_request(op == "W", a, s, d, e, ok);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (ok) begin
			wait_all_done(ok);
		end
		$display("mismatches %0d, timeouts %0d, other failures %0d",
			mismatches, timeouts, faults);
		if (mismatches == 0 && timeouts == 0 && faults == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
	parameter int WAYS = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  cache_geom_pkg::addr_t addr,
	input  cache_geom_pkg::strb_t wstrb,
	input  cache_geom_pkg::word_t wdata,
	output cache_geom_pkg::word_t rdata,
	output logic                  addr_ok,
	output logic                  data_ok,
	output logic                  rd_req,
	output cache_geom_pkg::addr_t rd_addr,
	input  logic                  rd_rdy,
	input  logic                  ret_valid,
	input  logic                  ret_last,
	input  cache_geom_pkg::word_t ret_data,
	output logic                  wr_req,
	output cache_geom_pkg::addr_t wr_addr,
	output cache_bus_pkg::wr_op_t wr_op,
	output cache_geom_pkg::strb_t wr_strb,
	output cache_geom_pkg::line_t wr_data,
	input  logic                  wr_rdy
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	localparam int WAY_W = $clog2(WAYS);

	// controller to ways
	index_t              arr_index;
	tag_t                arr_tag;
	logic [WAYS-1:0]     way_we;
	logic [1:0]          word_sel;
	word_t               arr_wdata;
	strb_t               arr_strb;
	logic [WAYS-1:0]     tag_install;
	logic [WAYS-1:0]     dirty_clear;

	// ways to selector
	logic [WAYS-1:0]     hits;
	logic [WAYS-1:0]     dirties;
	line_t [WAYS-1:0]    lines;
	tag_t [WAYS-1:0]     tags;

	// selector and lfsr back to controller
	logic                hit_any;
	logic                victim_dirty;
	tag_t                victim_tag;
	line_t               victim_line;
	logic [WAY_W-1:0]    victim_way;
	logic [WAY_W-1:0]    lfsr_way;
	logic                lookup_fire;
	logic [1:0]          word_off;
	logic                refill_beat_hit;

	// op_line sends the victim line
	// op_word carries the held write word in the low bits
	assign wr_data = (wr_op == op_line) ? victim_line : line_t'(arr_wdata);

	cache_ctrl #(.WAYS(WAYS)) cache_ctrl_i (
		.clk(clk), .rst_n(rst_n), .req(req), .we(we), .addr(addr),
		.wstrb(wstrb), .wdata(wdata), .hit_any(hit_any),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag), .lfsr_way(lfsr_way),
		.rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last),
		.ret_data(ret_data), .wr_rdy(wr_rdy),
		.addr_ok(addr_ok), .data_ok(data_ok), .arr_index(arr_index), .arr_tag(arr_tag),
		.way_we(way_we), .word_sel(word_sel), .arr_wdata(arr_wdata), .arr_strb(arr_strb),
		.tag_install(tag_install), .dirty_clear(dirty_clear), .victim_way(victim_way),
		.lookup_fire(lookup_fire), .word_off(word_off), .refill_beat_hit(refill_beat_hit),
		.rd_req(rd_req), .rd_addr(rd_addr), .wr_req(wr_req), .wr_addr(wr_addr),
		.wr_op(wr_op), .wr_strb(wr_strb)
	);

	// identical ways share the array port
	for (genvar i = 0; i < WAYS; i++) begin : g_way
		cache_way cache_way_i (
			.clk(clk), .rst_n(rst_n), .arr_index(arr_index), .arr_tag(arr_tag),
			.we(way_we[i]), .word_sel(word_sel), .arr_wdata(arr_wdata), .arr_strb(arr_strb),
			.tag_install(tag_install[i]), .dirty_clear(dirty_clear[i]),
			.hit(hits[i]), .dirty(dirties[i]), .line(lines[i]), .tag(tags[i])
		);
	end

	way_select #(.WAYS(WAYS)) way_select_i (
		.clk(clk), .rst_n(rst_n), .hits(hits), .dirties(dirties), .lines(lines),
		.tags(tags), .lookup_fire(lookup_fire), .word_off(word_off),
		.victim_way(victim_way), .ret_data(ret_data), .refill_beat_hit(refill_beat_hit),
		.hit_any(hit_any), .rdata(rdata), .victim_line(victim_line),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	victim_lfsr #(.WAYS(WAYS)) victim_lfsr_i (
		.clk(clk), .rst_n(rst_n), .way(lfsr_way)
	);

endmodule

// ==== hdl/way_select.sv ====
`timescale 1ns/1ps

module way_select #(
	parameter int WAYS = 2,
	localparam type way_sel_t = logic [$clog2(WAYS)-1:0]
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [WAYS-1:0]                  hits,
	input  logic [WAYS-1:0]                  dirties,
	input  cache_geom_pkg::line_t [WAYS-1:0] lines,
	input  cache_geom_pkg::tag_t [WAYS-1:0]  tags,
	input  logic                             lookup_fire,
	input  logic [1:0]                       word_off,
	input  way_sel_t                         victim_way,
	input  cache_geom_pkg::word_t            ret_data,
	input  logic                             refill_beat_hit,
	output logic                             hit_any,
	output cache_geom_pkg::word_t            rdata,
	output cache_geom_pkg::line_t            victim_line,
	output logic                             victim_dirty,
	output cache_geom_pkg::tag_t             victim_tag
);
	import cache_geom_pkg::*;

	logic [WAYS-1:0] hit_q;
	word_t           hit_word;

	// same cycle hit for the controller
	assign hit_any = |hits;

	// one cycle delay lines up with the bank read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hit_q <= '0;
		end else begin
			hit_q <= hits & {WAYS{lookup_fire}};
		end
	end

	// at most one way hits
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (hit_q[i]) begin
				hit_word = hit_word | lines[i][32*word_off +: 32];
			end
		end
	end

	// requested word straight off the bus during refill
	assign rdata = refill_beat_hit ? ret_data : hit_word;

	// victim fields for the writeback
	assign victim_line = lines[victim_way];
	assign victim_tag = tags[victim_way];
	assign victim_dirty = dirties[victim_way];

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int WAYS = 2,
	localparam type way_sel_t = logic [$clog2(WAYS)-1:0]
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req,
	input  logic                   we,
	input  cache_geom_pkg::addr_t  addr,
	input  cache_geom_pkg::strb_t  wstrb,
	input  cache_geom_pkg::word_t  wdata,
	input  logic                   hit_any,
	input  logic                   victim_dirty,
	input  cache_geom_pkg::tag_t   victim_tag,
	input  way_sel_t               lfsr_way,
	input  logic                   rd_rdy,
	input  logic                   ret_valid,
	input  logic                   ret_last,
	input  cache_geom_pkg::word_t  ret_data,
	input  logic                   wr_rdy,
	output logic                   addr_ok,
	output logic                   data_ok,
	output cache_geom_pkg::index_t arr_index,
	output cache_geom_pkg::tag_t   arr_tag,
	output logic [WAYS-1:0]        way_we,
	output logic [1:0]             word_sel,
	output cache_geom_pkg::word_t  arr_wdata,
	output cache_geom_pkg::strb_t  arr_strb,
	output logic [WAYS-1:0]        tag_install,
	output logic [WAYS-1:0]        dirty_clear,
	output way_sel_t               victim_way,
	output logic                   lookup_fire,
	output logic [1:0]             word_off,
	output logic                   refill_beat_hit,
	output logic                   rd_req,
	output cache_geom_pkg::addr_t  rd_addr,
	output logic                   wr_req,
	output cache_geom_pkg::addr_t  wr_addr,
	output cache_bus_pkg::wr_op_t  wr_op,
	output cache_geom_pkg::strb_t  wr_strb
);
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	ctrl_state_t     state;
	ctrl_state_t     state_nxt;
	addr_t           req_addr;
	strb_t           req_strb;
	word_t           req_wdata;
	index_t          req_index;
	tag_t            req_tag;
	logic [1:0]      req_word;
	logic            fire;
	logic            beat;
	logic            rd_acked;
	logic [1:0]      beat_cnt;
	logic            hit_done_q;
	logic            word_done_q;
	logic [WAYS-1:0] victim_hot;

	// core handshake
	assign addr_ok = (state == st_lookup);
	assign fire = req && addr_ok;
	assign lookup_fire = fire;

	// fields of the held request
	assign req_index = req_addr[OFFSET_W +: INDEX_W];
	assign req_tag = req_addr[OFFSET_W+INDEX_W +: TAG_W];
	assign req_word = req_addr[OFFSET_W-1:2];
	assign word_off = req_word;

	// beats only count once the line read was taken
	assign beat = (state == st_refill) && rd_acked && ret_valid;
	assign refill_beat_hit = beat && (beat_cnt == req_word);

	// hit and word write answer a cycle late
	// read miss answers on its own beat
	assign data_ok = hit_done_q || word_done_q || refill_beat_hit;

	always_comb begin
		victim_hot = '0;
		victim_hot[victim_way] = 1'b1;
	end

	// payload of the accepted request
	always_ff @(posedge clk) begin
		if (fire) begin
			req_addr <= addr;
			req_strb <= wstrb;
			req_wdata <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_lookup;
			victim_way <= '0;
			rd_acked <= 1'b0;
			beat_cnt <= 2'd0;
			hit_done_q <= 1'b0;
			word_done_q <= 1'b0;
		end else begin
			state <= state_nxt;
			hit_done_q <= fire && hit_any;
			word_done_q <= (state == st_word_write) && wr_rdy;
			// victim fixed at miss acceptance
			if (fire && !hit_any) begin
				victim_way <= lfsr_way;
			end
			if (beat && ret_last) begin
				rd_acked <= 1'b0;
			end else if (rd_req && rd_rdy) begin
				rd_acked <= 1'b1;
			end
			// word order 0 to 3
			if (beat && ret_last) begin
				beat_cnt <= 2'd0;
			end else if (beat) begin
				beat_cnt <= beat_cnt + 2'd1;
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_lookup: begin
				if (fire && !hit_any) begin
					// write miss skips allocation
					state_nxt = we ? st_word_write : st_miss;
				end
			end
			st_miss: begin
				// victim line and tag read out by now
				state_nxt = victim_dirty ? st_writeback : st_refill;
			end
			st_writeback: begin
				if (wr_rdy) begin
					state_nxt = st_refill;
				end
			end
			st_refill: begin
				if (beat && ret_last) begin
					state_nxt = st_lookup;
				end
			end
			st_word_write: begin
				if (wr_rdy) begin
					state_nxt = st_lookup;
				end
			end
			default: begin
				state_nxt = st_lookup;
			end
		endcase
	end

	// array port steering
	always_comb begin
		if (state == st_lookup) begin
			// core write hit under caller strobe
			arr_index = addr[OFFSET_W +: INDEX_W];
			arr_tag = addr[OFFSET_W+INDEX_W +: TAG_W];
			word_sel = addr[OFFSET_W-1:2];
			arr_wdata = wdata;
			arr_strb = wstrb;
			way_we = {WAYS{fire && we && hit_any}};
		end else begin
			// refill beats write whole words into the victim
			arr_index = req_index;
			arr_tag = req_tag;
			word_sel = beat_cnt;
			arr_wdata = (state == st_word_write) ? req_wdata : ret_data;
			arr_strb = '1;
			way_we = beat ? victim_hot : '0;
		end
	end

	// new tag goes in as the line read is taken
	assign tag_install = (rd_req && rd_rdy) ? victim_hot : '0;
	assign dirty_clear = (state == st_refill) ? victim_hot : '0;

	// memory read side
	assign rd_req = (state == st_refill) && !rd_acked;
	assign rd_addr = {req_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

	// memory write side
	assign wr_req = (state == st_writeback) || (state == st_word_write);
	assign wr_op = (state == st_writeback) ? op_line : op_word;
	assign wr_strb = (state == st_writeback) ? 4'hf : req_strb;
	assign wr_addr = (state == st_writeback) ?
		{victim_tag, req_index, {OFFSET_W{1'b0}}} : {req_addr[31:2], 2'b00};

endmodule

// ==== hdl/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cache_geom_pkg::index_t arr_index,
	input  cache_geom_pkg::tag_t   arr_tag,
	input  logic                   we,
	input  logic [1:0]             word_sel,
	input  cache_geom_pkg::word_t  arr_wdata,
	input  cache_geom_pkg::strb_t  arr_strb,
	input  logic                   tag_install,
	input  logic                   dirty_clear,
	output logic                   hit,
	output logic                   dirty,
	output cache_geom_pkg::line_t  line,
	output cache_geom_pkg::tag_t   tag
);
	import cache_geom_pkg::*;

	tag_t                tag_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid;
	logic [NUM_SETS-1:0] dirty_bits;
	word_t               rd_word [WORDS_PER_LINE];
	logic                wr_en;

	// tags sit in flops so the compare is same cycle
	assign tag = tag_mem[arr_index];
	assign hit = valid[arr_index] && (tag_mem[arr_index] == arr_tag);
	assign dirty = dirty_bits[arr_index];

	// write lands only in the way holding the line
	// refill installs the tag first so the victim hits here too
	assign wr_en = we && hit;

	always_ff @(posedge clk) begin
		if (tag_install) begin
			tag_mem[arr_index] <= arr_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			dirty_bits <= '0;
		end else begin
			if (tag_install) begin
				valid[arr_index] <= 1'b1;
			end
			// refill writes keep the line clean
			if (dirty_clear) begin
				dirty_bits[arr_index] <= 1'b0;
			end else if (wr_en) begin
				dirty_bits[arr_index] <= 1'b1;
			end
		end
	end

	// one bank per word of the line
	for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_bank
		word_t mem [NUM_SETS];

		always_ff @(posedge clk) begin
			// byte lanes under strobe
			for (int b = 0; b < 4; b++) begin
				if (wr_en && (word_sel == 2'(w)) && arr_strb[b]) begin
					mem[arr_index][8*b +: 8] <= arr_wdata[8*b +: 8];
				end
			end
			// synchronous read, one cycle
			rd_word[w] <= mem[arr_index];
		end
	end

	// pack banks into a line, word 0 low
	always_comb begin
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			line[32*w +: 32] = rd_word[w];
		end
	end

endmodule

// ==== hdl/victim_lfsr.sv ====
`timescale 1ns/1ps

module victim_lfsr #(
	parameter int WAYS = 2,
	localparam type way_sel_t = logic [$clog2(WAYS)-1:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	output way_sel_t way
);

	logic [15:0] lfsr_q;
	logic        feedback;

	// taps 16 14 13 11, maximal length
	assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

	// free running, any nonzero seed works
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr_q <= 16'hace1;
		end else begin
			lfsr_q <= {lfsr_q[14:0], feedback};
		end
	end

	// low bits pick the way
	assign way = way_sel_t'(lfsr_q);

endmodule

// ==== hdl/cache_bus_pkg.sv ====
package cache_bus_pkg;

	// miss handling states of the controller
	typedef enum logic [2:0] {
		st_lookup,
		st_miss,
		st_writeback,
		st_refill,
		st_word_write
	} ctrl_state_t;

	// memory write size
	// word write uses low word and strobe only
	typedef enum logic {
		op_word = 1'b0,
		op_line = 1'b1
	} wr_op_t;

endpackage

// ==== hdl/cache_geom_pkg.sv ====
package cache_geom_pkg;

	// core side byte address and data word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// one strobe bit per byte lane
	typedef logic [3:0] strb_t;

	// address split is tag | index | byte offset
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 5;
	localparam int TAG_W = 32 - INDEX_W - OFFSET_W;

	// sets per way
	localparam int NUM_SETS = 1 << INDEX_W;

	// four words make one line
	localparam int WORDS_PER_LINE = 4;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;

	// word 0 in the low bits
	typedef logic [WORDS_PER_LINE*32-1:0] line_t;

endpackage
